// ==== project.f ====
hdl/rate_ctrl_pkg.sv
hdl/axis_job_if.sv
hdl/body_frame_controller.sv
hdl/axis_pid.sv
hdl/motor_mixer.sv
hdl/rate_control_top.sv
verification/tb_rate_control.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the rate loop testbench with Verilator, run it, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -Wno-fatal --top-module tb_rate_control -f project.f \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_rate_control 2>&1 | tee sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== verification/tb_rate_control.sv ====
// Testbench for rate_control_top with directed and random jobs checked against a reference model.
// Assumes the default gains and a +-4000 rate clamp. Only one job is in flight at a time.
// Idle gaps stay far below the engine watchdog apart from one deliberate long idle.
`timescale 1ns/1ps
`default_nettype none

module tb_rate_control import rate_ctrl_pkg::*; ();

	localparam int RATE_LO = -4000;
	localparam int RATE_HI = 4000;
	localparam int K_P = 4;
	localparam int K_P_SHIFT = 2;
	localparam int K_I = 1;
	localparam int K_I_SHIFT = 3;
	localparam int K_D = 2;
	localparam int K_D_SHIFT = 2;
	localparam int JOB_TIMEOUT = 40;
	// outlasts both checker waits
	localparam int CHECK_TIMEOUT = 3 * JOB_TIMEOUT;
	localparam int WATCHDOG_IDLE = 1100;

	logic us_clk;
	logic resetn;
	logic start_signal;
	motor_t throttle;
	rate_t yaw_target, roll_target, pitch_target;
	rate_t yaw_rotation, roll_rotation, pitch_rotation;
	rate_t roll_angle_error, pitch_angle_error;
	rate_t yaw_rate_out, roll_rate_out, pitch_rate_out;
	logic complete_signal;
	motor_t motor_fl, motor_fr, motor_rl, motor_rr;
	logic motor_valid;

	// model history per axis (0 yaw 1 roll 2 pitch)
	longint integ_m [3];
	longint prev_m [3];
	// seven expected values per job with rates before motors
	longint exp_q [$];
	longint latch_q [$];
	longint cyc = 0;
	logic [31:0] rng_state;
	int errors = 0;
	int jobs_sent = 0;
	int jobs_checked = 0;

	rate_control_top #(
		.RATE_MIN(rate_t'(RATE_LO)),
		.RATE_MAX(rate_t'(RATE_HI))
	) u_rate_control_top (.*);

	always #10 us_clk = ~us_clk;

	// rising edge count read on falling edges
	always @(posedge us_clk) cyc <= cyc + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// full scale or near zero with equal odds
	function rate_t rand_rate();
		logic [31:0] r;
		r = next_rand();
		if (r[31])
			return rate_t'(r[15:0]);
		else
			return rate_t'($signed(r[9:0]));
	endfunction

	function automatic longint clamp_val(input longint v, input longint lo, input longint hi);
		if (v < lo)
			return lo;
		if (v > hi)
			return hi;
		return v;
	endfunction

	function void clear_history();
		for (int a = 0; a < 3; a++) begin
			integ_m[a] = 0;
			prev_m[a] = 0;
		end
	endfunction

	// one PID job on axis a that also updates the model history
	function automatic longint pid_model(input int a, input longint tgt, input longint act);
		longint e;
		longint p;
		longint i;
		longint d;
		e = tgt - act;
		integ_m[a] = clamp_val(integ_m[a] + e, RATE_LO, RATE_HI);
		p = (e * K_P) >>> K_P_SHIFT;
		i = (integ_m[a] * K_I) >>> K_I_SHIFT;
		d = ((e - prev_m[a]) * K_D) >>> K_D_SHIFT;
		prev_m[a] = e;
		return clamp_val(p + i + d, RATE_LO, RATE_HI);
	endfunction

	// expected result of the job latched at the next rising edge
	function automatic void queue_expected();
		longint y_tgt, r_tgt, p_tgt;
		longint y_act, r_act, p_act;
		longint y_out, r_out, p_out;
		longint y_i, r_i, p_i;
		longint thr;
		// roll and pitch pick up the angle error
		y_tgt = clamp_val(longint'(yaw_target), RATE_LO, RATE_HI);
		r_tgt = clamp_val(longint'(roll_target) + longint'(roll_angle_error), RATE_LO, RATE_HI);
		p_tgt = clamp_val(longint'(pitch_target) + longint'(pitch_angle_error), RATE_LO, RATE_HI);
		// imu yaw and pitch flipped with saturation at the 16 bit range
		y_act = clamp_val(-longint'(yaw_rotation), -32768, 32767);
		r_act = longint'(roll_rotation);
		p_act = clamp_val(-longint'(pitch_rotation), -32768, 32767);
		y_out = pid_model(0, y_tgt, y_act);
		r_out = pid_model(1, r_tgt, r_act);
		p_out = pid_model(2, p_tgt, p_act);
		// mixer works on whole units
		y_i = y_out >>> RATE_FRAC_BITS;
		r_i = r_out >>> RATE_FRAC_BITS;
		p_i = p_out >>> RATE_FRAC_BITS;
		thr = longint'(throttle);
		exp_q.push_back(y_out);
		exp_q.push_back(r_out);
		exp_q.push_back(p_out);
		exp_q.push_back(clamp_val(thr + p_i + r_i - y_i, 0, MOTOR_MAX));
		exp_q.push_back(clamp_val(thr + p_i - r_i + y_i, 0, MOTOR_MAX));
		exp_q.push_back(clamp_val(thr - p_i + r_i + y_i, 0, MOTOR_MAX));
		exp_q.push_back(clamp_val(thr - p_i - r_i - y_i, 0, MOTOR_MAX));
		latch_q.push_back(cyc + 1);
		jobs_sent++;
	endfunction

	task automatic compare_value(input string name, input logic signed [63:0] got,
		input longint exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task finish_run();
		$display("Errors: %0d, jobs checked: %0d of %0d", errors, jobs_checked, jobs_sent);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic set_inputs(input int yt, rt, pt, yr, rr, pr, rae, pae, input int thr);
		yaw_target = rate_t'(yt);
		roll_target = rate_t'(rt);
		pitch_target = rate_t'(pt);
		yaw_rotation = rate_t'(yr);
		roll_rotation = rate_t'(rr);
		pitch_rotation = rate_t'(pr);
		roll_angle_error = rate_t'(rae);
		pitch_angle_error = rate_t'(pae);
		throttle = motor_t'(thr);
	endtask

	task automatic wait_checked();
		int n;
		n = 0;
		while (jobs_checked < jobs_sent && n < CHECK_TIMEOUT) begin
			@(negedge us_clk);
			n++;
		end
		if (jobs_checked < jobs_sent) begin
			errors++;
			$display("Timeout: job %0d was never completed and checked", jobs_sent);
			finish_run();
		end
	endtask

	// start stays high for high_cycles falling edges and inputs stay until checked
	task automatic run_job(input int gap, input int high_cycles);
		repeat (gap) @(negedge us_clk);
		@(negedge us_clk);
		start_signal = 1'b1;
		queue_expected();
		repeat (high_cycles) @(negedge us_clk);
		start_signal = 1'b0;
		wait_checked();
	endtask

	initial begin : check_proc
		longint latch;
		longint e [7];
		int n;
		forever begin
			@(negedge us_clk);
			if (latch_q.size() == 0) begin
				if (complete_signal === 1'b1 || motor_valid === 1'b1) begin
					errors++;
					$display("Fail %0t: complete_signal or motor_valid pulsed with no job",
						$time);
				end
			end else begin
				n = 0;
				while (complete_signal !== 1'b1 && n < JOB_TIMEOUT) begin
					@(negedge us_clk);
					n++;
				end
				if (complete_signal !== 1'b1) begin
					errors++;
					$display("Timeout: complete_signal missing after %0d cycles", JOB_TIMEOUT);
					finish_run();
				end else begin
					latch = latch_q.pop_front();
					for (int k = 0; k < 7; k++)
						e[k] = exp_q.pop_front();
					compare_value("complete_signal delay", cyc - latch, 5);
					compare_value("yaw_rate_out", yaw_rate_out, e[0]);
					compare_value("roll_rate_out", roll_rate_out, e[1]);
					compare_value("pitch_rate_out", pitch_rate_out, e[2]);
					n = 0;
					while (motor_valid !== 1'b1 && n < JOB_TIMEOUT) begin
						@(negedge us_clk);
						n++;
					end
					if (motor_valid !== 1'b1) begin
						errors++;
						$display("Timeout: motor_valid missing after %0d cycles", JOB_TIMEOUT);
						finish_run();
					end else begin
						compare_value("motor_valid delay", cyc - latch, 6);
						// complete is a single cycle and the rates are still held
						compare_value("complete_signal width", complete_signal, 0);
						compare_value("yaw_rate_out held", yaw_rate_out, e[0]);
						compare_value("motor_fl", motor_fl, e[3]);
						compare_value("motor_fr", motor_fr, e[4]);
						compare_value("motor_rl", motor_rl, e[5]);
						compare_value("motor_rr", motor_rr, e[6]);
						// motor strobe lasts one cycle
						@(negedge us_clk);
						compare_value("motor_valid width", motor_valid, 0);
						jobs_checked++;
					end
				end
			end
		end
	end

	initial begin : stimulus
		us_clk = 1'b0;
		resetn = 1'b0;
		start_signal = 1'b0;
		rng_state = 32'h4331cc07;
		set_inputs(0, 0, 0, 0, 0, 0, 0, 0, 0);
		clear_history();
		repeat (4) @(negedge us_clk);
		resetn = 1'b1;

		// quiet outputs after reset
		@(negedge us_clk);
		compare_value("yaw_rate_out after reset", yaw_rate_out, 0);
		compare_value("roll_rate_out after reset", roll_rate_out, 0);
		compare_value("pitch_rate_out after reset", pitch_rate_out, 0);
		compare_value("motor_fl after reset", motor_fl, 0);
		compare_value("motor_fr after reset", motor_fr, 0);
		compare_value("motor_rl after reset", motor_rl, 0);
		compare_value("motor_rr after reset", motor_rr, 0);
		for (int i = 0; i < 20; i++) begin
			@(negedge us_clk);
			compare_value("complete_signal idle", complete_signal, 0);
			compare_value("motor_valid idle", motor_valid, 0);
		end

		// small values with exact latency
		set_inputs(16, 32, -24, 8, -12, 20, 4, -8, 1500);
		run_job(0, 1);

		// rate saturation both ways and then motor clamp high and low
		set_inputs(30000, -30000, 30000, 30000, 30000, 30000, 100, -100, 4095);
		run_job(2, 1);
		set_inputs(30000, -30000, 30000, -32768, 30000, -32768, 100, -100, 0);
		run_job(2, 1);

		// long idle lets the watchdog drop the engine history
		repeat (WATCHDOG_IDLE) @(negedge us_clk);
		clear_history();

		// constant error builds the integral and a step at job 5 kicks the derivative
		for (int j = 0; j < 10; j++) begin
			if (j < 5)
				set_inputs(80, 48, -64, -16, 8, 12, 0, 0, 2048);
			else
				set_inputs(160, -48, 64, -16, 8, 12, 0, 0, 2048);
			run_job(0, 1);
		end

		// start held across two job times gives one job only
		set_inputs(40, -40, 24, 4, 4, -4, 8, 8, 1000);
		run_job(2, 15);
		run_job(0, 1);

		// random jobs with short idle gaps
		for (int j = 0; j < 200; j++) begin
			set_inputs(rand_rate(), rand_rate(), rand_rate(), rand_rate(), rand_rate(),
				rand_rate(), rand_rate(), rand_rate(), int'(next_rand() & 32'hFFF));
			run_job(int'(next_rand() & 32'hF), 1);
		end

		repeat (10) @(negedge us_clk);
		if (latch_q.size() != 0 || jobs_checked != jobs_sent) begin
			errors++;
			$display("Jobs left unchecked at the end: %0d sent, %0d checked",
				jobs_sent, jobs_checked);
		end
		finish_run();
	end

endmodule

`default_nettype wire

// ==== hdl/rate_control_top.sv ====
// Rate loop top: controller, three PID engines and the quad-X mixer.
// Gains and rate limits are set here and passed down, one gain set per axis.
// complete_signal comes 5 cycles after the latching edge, motor_valid one cycle later.
`timescale 1ns/1ps
`default_nettype none

module rate_control_top import rate_ctrl_pkg::*; #(
	parameter rate_t RATE_MIN = -16'sd4000,
	parameter rate_t RATE_MAX = 16'sd4000,
	parameter int YAW_K_P = 4,
	parameter int YAW_K_P_SHIFT = 2,
	parameter int YAW_K_I = 1,
	parameter int YAW_K_I_SHIFT = 3,
	parameter int YAW_K_D = 2,
	parameter int YAW_K_D_SHIFT = 2,
	parameter int ROLL_K_P = 4,
	parameter int ROLL_K_P_SHIFT = 2,
	parameter int ROLL_K_I = 1,
	parameter int ROLL_K_I_SHIFT = 3,
	parameter int ROLL_K_D = 2,
	parameter int ROLL_K_D_SHIFT = 2,
	parameter int PITCH_K_P = 4,
	parameter int PITCH_K_P_SHIFT = 2,
	parameter int PITCH_K_I = 1,
	parameter int PITCH_K_I_SHIFT = 3,
	parameter int PITCH_K_D = 2,
	parameter int PITCH_K_D_SHIFT = 2
) (
	input  wire          us_clk,
	input  wire          resetn,
	input  wire          start_signal,
	input  wire motor_t  throttle,
	input  wire rate_t   yaw_target,
	input  wire rate_t   roll_target,
	input  wire rate_t   pitch_target,
	input  wire rate_t   yaw_rotation,
	input  wire rate_t   roll_rotation,
	input  wire rate_t   pitch_rotation,
	input  wire rate_t   roll_angle_error,
	input  wire rate_t   pitch_angle_error,
	output rate_t        yaw_rate_out,
	output rate_t        roll_rate_out,
	output rate_t        pitch_rate_out,
	output logic         complete_signal,
	output motor_t       motor_fl,
	output motor_t       motor_fr,
	output motor_t       motor_rl,
	output motor_t       motor_rr,
	output logic         motor_valid
);

	// one job channel per axis
	axis_job_if yaw_job ();
	axis_job_if roll_job ();
	axis_job_if pitch_job ();

	body_frame_controller #(
		.RATE_MIN(RATE_MIN),
		.RATE_MAX(RATE_MAX)
	) u_body_frame_controller (
		.us_clk(us_clk),
		.resetn(resetn),
		.start_signal(start_signal),
		.yaw_target(yaw_target),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.yaw_rotation(yaw_rotation),
		.roll_rotation(roll_rotation),
		.pitch_rotation(pitch_rotation),
		.roll_angle_error(roll_angle_error),
		.pitch_angle_error(pitch_angle_error),
		.yaw_job(yaw_job.ctrl),
		.roll_job(roll_job.ctrl),
		.pitch_job(pitch_job.ctrl),
		.yaw_rate_out(yaw_rate_out),
		.roll_rate_out(roll_rate_out),
		.pitch_rate_out(pitch_rate_out),
		.complete_signal(complete_signal)
	);

	axis_pid #(
		.RATE_MIN(RATE_MIN), .RATE_MAX(RATE_MAX),
		.K_P(YAW_K_P), .K_P_SHIFT(YAW_K_P_SHIFT),
		.K_I(YAW_K_I), .K_I_SHIFT(YAW_K_I_SHIFT),
		.K_D(YAW_K_D), .K_D_SHIFT(YAW_K_D_SHIFT)
	) u_yaw_pid (
		.us_clk(us_clk),
		.resetn(resetn),
		.job(yaw_job.pid)
	);

	axis_pid #(
		.RATE_MIN(RATE_MIN), .RATE_MAX(RATE_MAX),
		.K_P(ROLL_K_P), .K_P_SHIFT(ROLL_K_P_SHIFT),
		.K_I(ROLL_K_I), .K_I_SHIFT(ROLL_K_I_SHIFT),
		.K_D(ROLL_K_D), .K_D_SHIFT(ROLL_K_D_SHIFT)
	) u_roll_pid (
		.us_clk(us_clk),
		.resetn(resetn),
		.job(roll_job.pid)
	);

	axis_pid #(
		.RATE_MIN(RATE_MIN), .RATE_MAX(RATE_MAX),
		.K_P(PITCH_K_P), .K_P_SHIFT(PITCH_K_P_SHIFT),
		.K_I(PITCH_K_I), .K_I_SHIFT(PITCH_K_I_SHIFT),
		.K_D(PITCH_K_D), .K_D_SHIFT(PITCH_K_D_SHIFT)
	) u_pitch_pid (
		.us_clk(us_clk),
		.resetn(resetn),
		.job(pitch_job.pid)
	);

	// mixer captures the rates as they are published
	motor_mixer u_motor_mixer (
		.us_clk(us_clk),
		.resetn(resetn),
		.capture(complete_signal),
		.yaw_rate(yaw_rate_out),
		.roll_rate(roll_rate_out),
		.pitch_rate(pitch_rate_out),
		.throttle(throttle),
		.motor_fl(motor_fl),
		.motor_fr(motor_fr),
		.motor_rl(motor_rl),
		.motor_rr(motor_rr),
		.motor_valid(motor_valid)
	);

endmodule

`default_nettype wire

// ==== hdl/motor_mixer.sv ====
// Quad-X mixer using the integer part of each rate command.
// Motors clamp to 0..MOTOR_MAX and update only on capture, with motor_valid alongside.
`timescale 1ns/1ps
`default_nettype none

module motor_mixer import rate_ctrl_pkg::*; (
	input  wire          us_clk,
	input  wire          resetn,
	input  wire          capture,
	input  wire rate_t   yaw_rate,
	input  wire rate_t   roll_rate,
	input  wire rate_t   pitch_rate,
	input  wire motor_t  throttle,
	output motor_t       motor_fl,
	output motor_t       motor_fr,
	output motor_t       motor_rl,
	output motor_t       motor_rr,
	output logic         motor_valid
);

	// throttle plus three 12 bit terms fits easily
	typedef logic signed [15:0] mix_t;

	mix_t thr;
	mix_t yaw_i;
	mix_t roll_i;
	mix_t pitch_i;
	mix_t fl_sum;
	mix_t fr_sum;
	mix_t rl_sum;
	mix_t rr_sum;

	// negative sums floor at zero
	function automatic motor_t clamp_motor(input mix_t v);
		if (v[15])
			return '0;
		else if (v > mix_t'(MOTOR_MAX))
			return motor_t'(MOTOR_MAX);
		else
			return v[MOTOR_W-1:0];
	endfunction

	// drop the fraction, keep the sign
	assign yaw_i = mix_t'(yaw_rate >>> RATE_FRAC_BITS);
	assign roll_i = mix_t'(roll_rate >>> RATE_FRAC_BITS);
	assign pitch_i = mix_t'(pitch_rate >>> RATE_FRAC_BITS);
	assign thr = mix_t'({4'b0000, throttle});

	// front motors gain on pitch, left motors on roll
	assign fl_sum = thr + pitch_i + roll_i - yaw_i;
	assign fr_sum = thr + pitch_i - roll_i + yaw_i;
	assign rl_sum = thr - pitch_i + roll_i + yaw_i;
	assign rr_sum = thr - pitch_i - roll_i - yaw_i;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motor_fl <= '0;
			motor_fr <= '0;
			motor_rl <= '0;
			motor_rr <= '0;
			motor_valid <= 1'b0;
		end else begin
			// single cycle strobe with the new values
			motor_valid <= capture;
			if (capture) begin
				motor_fl <= clamp_motor(fl_sum);
				motor_fr <= clamp_motor(fr_sum);
				motor_rl <= clamp_motor(rl_sum);
				motor_rr <= clamp_motor(rr_sum);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/axis_pid.sv ====
// PID engine for one axis, one step per clock: ERR, INTEG, SUM, then a done pulse.
// Each gain term is (value * K) >>> K_SHIFT. Integral and output clamp to RATE_MIN..RATE_MAX.
// Integral and previous error survive between jobs and clear on reset or a long idle hold.
`timescale 1ns/1ps
`default_nettype none

module axis_pid import rate_ctrl_pkg::*; #(
	parameter rate_t RATE_MIN = -16'sd4000,
	parameter rate_t RATE_MAX = 16'sd4000,
	parameter int K_P = 4,
	parameter int K_P_SHIFT = 2,
	parameter int K_I = 1,
	parameter int K_I_SHIFT = 3,
	parameter int K_D = 2,
	parameter int K_D_SHIFT = 2
) (
	input wire       us_clk,
	input wire       resetn,
	axis_job_if.pid  job
);

	// one extra bit so target minus actual never wraps
	typedef logic signed [RATE_W:0] err_t;

	localparam int WD_W = $clog2(HOLD_WATCHDOG + 1);

	pid_state_e state;

	err_t err;
	err_t prev_err;
	rate_t integ;

	// idle watchdog
	logic [WD_W-1:0] hold_cnt;
	logic wd_clear;

	wide_t p_term;
	wide_t i_term;
	wide_t d_term;
	wide_t pid_sum;

	assign wd_clear = job.hold && (hold_cnt == WD_W'(HOLD_WATCHDOG));

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			hold_cnt <= '0;
		else if (!job.hold)
			hold_cnt <= '0;
		else if (!wd_clear)
			hold_cnt <= hold_cnt + 1'b1;
	end

	// gain terms, integral is already updated when SUM runs
	always_comb begin
		p_term = (wide_t'(err) * wide_t'(K_P)) >>> K_P_SHIFT;
		i_term = (wide_t'(integ) * wide_t'(K_I)) >>> K_I_SHIFT;
		d_term = ((wide_t'(err) - wide_t'(prev_err)) * wide_t'(K_D)) >>> K_D_SHIFT;
		pid_sum = p_term + i_term + d_term;
	end

	// step sequence and handshake
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= IDLE;
			job.active <= 1'b0;
			job.done <= 1'b0;
			job.rate_out <= '0;
			err <= '0;
		end else begin
			case (state)
				IDLE: begin
					job.done <= 1'b0;
					if (job.start) begin
						state <= ERR;
						job.active <= 1'b1;
					end
				end
				ERR: begin
					err <= err_t'(job.target) - err_t'(job.actual);
					state <= INTEG;
				end
				INTEG: begin
					state <= SUM;
				end
				SUM: begin
					job.rate_out <= sat_rate(pid_sum, RATE_MIN, RATE_MAX);
					job.done <= 1'b1;
					state <= DONE;
				end
				DONE: begin
					job.done <= 1'b0;
					job.active <= 1'b0;
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// controller history, kept across jobs
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			integ <= '0;
			prev_err <= '0;
		end else if (wd_clear) begin
			integ <= '0;
			prev_err <= '0;
		end else if (state == INTEG) begin
			integ <= sat_rate(wide_t'(integ) + wide_t'(err), RATE_MIN, RATE_MAX);
		end else if (state == SUM) begin
			prev_err <= err;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/body_frame_controller.sv ====
// Latches one set of targets and IMU rates per start request and runs three PID jobs.
// Start is taken on a rising edge seen while WAITING. Edges during a job are dropped.
// IMU rates must already be in 12.4. Yaw and pitch are negated, roll is used as is.
`timescale 1ns/1ps
`default_nettype none

module body_frame_controller import rate_ctrl_pkg::*; #(
	parameter rate_t RATE_MIN = -16'sd4000,
	parameter rate_t RATE_MAX = 16'sd4000
) (
	input  wire         us_clk,
	input  wire         resetn,
	input  wire         start_signal,
	input  wire rate_t  yaw_target,
	input  wire rate_t  roll_target,
	input  wire rate_t  pitch_target,
	input  wire rate_t  yaw_rotation,
	input  wire rate_t  roll_rotation,
	input  wire rate_t  pitch_rotation,
	input  wire rate_t  roll_angle_error,
	input  wire rate_t  pitch_angle_error,
	axis_job_if.ctrl    yaw_job,
	axis_job_if.ctrl    roll_job,
	axis_job_if.ctrl    pitch_job,
	output rate_t       yaw_rate_out,
	output rate_t       roll_rate_out,
	output rate_t       pitch_rate_out,
	output logic        complete_signal
);

	bfc_state_e state, next_state;

	// start edge detect
	logic start_armed;
	logic start_take;
	logic job_start;

	logic all_active;
	logic all_done;

	// rising edge only counts when idle
	assign start_take = start_signal && start_armed && (state == STATE_WAITING);

	assign all_active = yaw_job.active && roll_job.active && pitch_job.active;
	assign all_done = yaw_job.done && roll_job.done && pitch_job.done;

	// re-arm once the request line has been low
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_armed <= 1'b0;
			job_start <= 1'b0;
		end else begin
			if (!start_signal)
				start_armed <= 1'b1;
			else if (start_armed)
				start_armed <= 1'b0;
			// engines see this at the next edge
			job_start <= start_take;
		end
	end

	// latch corrected targets and actuals on the accepted edge
	always_ff @(posedge us_clk) begin
		if (start_take) begin
			// yaw has no outer angle loop
			yaw_job.target <= sat_rate(wide_t'(yaw_target), RATE_MIN, RATE_MAX);
			roll_job.target <= sat_rate(wide_t'(roll_target) + wide_t'(roll_angle_error),
				RATE_MIN, RATE_MAX);
			pitch_job.target <= sat_rate(wide_t'(pitch_target) + wide_t'(pitch_angle_error),
				RATE_MIN, RATE_MAX);
			// imu sign convention, -32768 would wrap on negation
			yaw_job.actual <= sat_rate(-wide_t'(yaw_rotation), RATE_T_MIN, RATE_T_MAX);
			roll_job.actual <= roll_rotation;
			pitch_job.actual <= sat_rate(-wide_t'(pitch_rotation), RATE_T_MIN, RATE_T_MAX);
		end
	end

	assign yaw_job.start = job_start;
	assign roll_job.start = job_start;
	assign pitch_job.start = job_start;

	// idle indication doubles as the engines' watchdog input
	assign yaw_job.hold = (state == STATE_WAITING);
	assign roll_job.hold = (state == STATE_WAITING);
	assign pitch_job.hold = (state == STATE_WAITING);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= STATE_WAITING;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			STATE_WAITING:  next_state = start_take ? STATE_STARTING : STATE_WAITING;
			STATE_STARTING: next_state = all_active ? STATE_ACTIVE : STATE_STARTING;
			STATE_ACTIVE:   next_state = all_done ? STATE_COMPLETE : STATE_ACTIVE;
			STATE_COMPLETE: next_state = STATE_WAITING;
			default:        next_state = STATE_WAITING;
		endcase
	end

	// results move out together with the complete state
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			yaw_rate_out <= '0;
			roll_rate_out <= '0;
			pitch_rate_out <= '0;
		end else if (state == STATE_ACTIVE && all_done) begin
			yaw_rate_out <= yaw_job.rate_out;
			roll_rate_out <= roll_job.rate_out;
			pitch_rate_out <= pitch_job.rate_out;
		end
	end

	assign complete_signal = (state == STATE_COMPLETE);

endmodule

`default_nettype wire

// ==== hdl/axis_job_if.sv ====
// One axis job between the body-frame controller and its PID engine.
// target and actual must stay stable from start until done.
`timescale 1ns/1ps
`default_nettype none

interface axis_job_if import rate_ctrl_pkg::*; ();

	// controller side
	// single cycle job request
	logic start;
	// high while the controller sits idle
	logic hold;
	rate_t target;
	rate_t actual;

	// engine side
	// busy from the cycle after start until done
	logic active;
	// single cycle pulse with a valid result
	logic done;
	// held until the next done
	rate_t rate_out;

	modport ctrl (
		output start, hold, target, actual,
		input  active, done, rate_out
	);

	modport pid (
		input  start, hold, target, actual,
		output active, done, rate_out
	);

endinterface

`default_nettype wire

// ==== hdl/rate_ctrl_pkg.sv ====
// Shared types, constants and helpers for the rate loop.
// Rates are signed 12.4 fixed point. Motor commands and throttle are unsigned 12 bit.
// wide_t holds intermediate products and sums, so keep gains well under 16 bits.
`default_nettype none

package rate_ctrl_pkg;

	// rate format
	localparam int RATE_W = 16;
	localparam int RATE_FRAC_BITS = 4;
	typedef logic signed [RATE_W-1:0] rate_t;

	// full range of rate_t, for clamping sign flips
	localparam rate_t RATE_T_MIN = 16'sh8000;
	localparam rate_t RATE_T_MAX = 16'sh7FFF;

	// motor command format
	localparam int MOTOR_W = 12;
	localparam int MOTOR_MAX = 4095;
	typedef logic [MOTOR_W-1:0] motor_t;

	// headroom for gain products
	localparam int WIDE_W = 40;
	typedef logic signed [WIDE_W-1:0] wide_t;

	// idle cycles before the engines drop their history
	localparam int HOLD_WATCHDOG = 1000;

	// one-hot controller states
	typedef enum logic [3:0] {
		STATE_WAITING  = 4'b0001,
		STATE_STARTING = 4'b0010,
		STATE_ACTIVE   = 4'b0100,
		STATE_COMPLETE = 4'b1000
	} bfc_state_e;

	// pid engine steps
	typedef enum logic [2:0] {IDLE, ERR, INTEG, SUM, DONE} pid_state_e;

	// clamp a wide signed value into [lo, hi]
	function automatic rate_t sat_rate(input wide_t val, input rate_t lo, input rate_t hi);
		if (val < wide_t'(lo))
			return lo;
		else if (val > wide_t'(hi))
			return hi;
		else
			return val[RATE_W-1:0];
	endfunction

endpackage

`default_nettype wire
